// File: hdl/rv32i_mem_pkg.sv
// shared word, mask, funct3 and write-back select types plus reset and credit constants
package rv32i_mem_pkg;

    // basic datapath widths
    typedef logic [31:0] rv_word_t;
    typedef logic [3:0]  byte_mask_t;
    typedef logic [4:0]  reg_idx_t;

    // RV32I load funct3 encodings
    typedef enum logic [2:0] {
        lb  = 3'b000,
        lh  = 3'b001,
        lw  = 3'b010,
        lbu = 3'b100,
        lhu = 3'b101
    } load_funct3_t;

    // RV32I store funct3 encodings
    typedef enum logic [2:0] {
        sb = 3'b000,
        sh = 3'b001,
        sw = 3'b010
    } store_funct3_t;

    // write-back source select
    typedef enum logic [2:0] {
        sel_alu      = 3'b000,
        sel_u_imm    = 3'b001,
        sel_pc_plus4 = 3'b010,
        sel_br_en    = 3'b011,
        sel_load     = 3'b100
    } wb_sel_t;

    localparam rv_word_t PC_RESET = 32'h4000_0000; // boot address

    // credits granted by the write-back consumer after reset
    localparam int WB_CREDITS = 2;

    localparam int CREDIT_W = 2; // holds 0..WB_CREDITS

    // slots the execute side may fill after reset
    localparam int EXE_MEM_SLOTS = 1;

endpackage : rv32i_mem_pkg

// File: hdl/exe_mem_reg.sv
// EXE/MEM pipeline register with address alignment, byte mask, store lane shift and misalign check
`timescale 1ns/1ps

module exe_mem_reg import rv32i_mem_pkg::*; (
    input  logic          clk,
    input  logic          rst,
    input  logic          ex_valid_i,
    input  rv_word_t      ex_alu_i,
    input  rv_word_t      ex_pc_i,
    input  rv_word_t      ex_rs2_i,
    input  rv_word_t      ex_u_imm_i,
    input  logic          ex_br_en_i,
    input  logic          ex_read_i,
    input  logic          ex_write_i,
    input  load_funct3_t  ex_load_f3_i,
    input  store_funct3_t ex_store_f3_i,
    input  wb_sel_t       ex_wb_sel_i,
    input  reg_idx_t      ex_rd_i,
    input  logic          ex_reg_we_i,
    input  logic          slot_free_i,
    output logic          slot_valid_o,
    output rv_word_t      alu_o,
    output rv_word_t      pc_o,
    output rv_word_t      u_imm_o,
    output logic          br_en_o,
    output logic          read_o,
    output logic          write_o,
    output load_funct3_t  load_f3_o,
    output wb_sel_t       wb_sel_o,
    output reg_idx_t      rd_o,
    output logic          reg_we_o,
    output rv_word_t      addr_o,
    output byte_mask_t    mask_o,
    output rv_word_t      wdata_o,
    output logic [1:0]    offset_o,
    output logic          misaligned_o
);

    logic          staged;   // fields captured, alignment pending
    rv_word_t      rs2_q;
    store_funct3_t store_f3_q;

    logic [1:0]    off;
    logic          acc_byte;
    logic          acc_half;
    byte_mask_t    mask_d;
    logic          mis_d;

    // first step: capture the execute results
    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            staged   <= 1'b0;
            read_o   <= 1'b0;
            write_o  <= 1'b0;
            reg_we_o <= 1'b0;
            pc_o     <= PC_RESET;
        end else begin
            staged <= ex_valid_i;
            if (ex_valid_i) begin
                read_o   <= ex_read_i;
                write_o  <= ex_write_i;
                reg_we_o <= ex_reg_we_i;
                pc_o     <= ex_pc_i;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (ex_valid_i) begin
            alu_o      <= ex_alu_i;
            rs2_q      <= ex_rs2_i;
            u_imm_o    <= ex_u_imm_i;
            br_en_o    <= ex_br_en_i;
            load_f3_o  <= ex_load_f3_i;
            store_f3_q <= ex_store_f3_i;
            wb_sel_o   <= ex_wb_sel_i;
            rd_o       <= ex_rd_i;
        end
    end

    assign off = alu_o[1:0];

    // access width from whichever funct3 applies
    always_comb begin
        acc_byte = 1'b0;
        acc_half = 1'b0;
        if (read_o) begin
            acc_byte = (load_f3_o == lb) || (load_f3_o == lbu);
            acc_half = (load_f3_o == lh) || (load_f3_o == lhu);
        end else if (write_o) begin
            acc_byte = (store_f3_q == sb);
            acc_half = (store_f3_q == sh);
        end
    end

    always_comb begin
        if (acc_byte) begin
            mask_d = byte_mask_t'(4'b0001 << off);
        end else if (acc_half) begin
            mask_d = byte_mask_t'(4'b0011 << off);
        end else begin
            mask_d = 4'b1111; // word
        end
        // half crossing the word, or word off its boundary
        mis_d = (read_o || write_o) &&
                ((acc_half && (off == 2'd3)) || (!acc_byte && !acc_half && (off != 2'd0)));
    end

    // second step: aligned access fields, slot becomes visible
    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            slot_valid_o <= 1'b0;
            misaligned_o <= 1'b0;
        end else if (staged) begin
            slot_valid_o <= 1'b1;
            misaligned_o <= mis_d;
        end else if (slot_free_i) begin
            slot_valid_o <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (staged) begin
            addr_o   <= {alu_o[31:2], 2'b00};
            mask_o   <= mask_d;
            wdata_o  <= rs2_q << {off, 3'b000}; // rs2 moved into its byte lanes
            offset_o <= off;
        end
    end

endmodule : exe_mem_reg

// File: hdl/dmem_ctrl.sv
// FSM sequencing each slot through data memory access and retirement
`timescale 1ns/1ps

module dmem_ctrl (
    input  logic clk,
    input  logic rst,
    input  logic slot_valid_i,
    input  logic mem_op_i,
    input  logic misaligned_i,
    input  logic dmem_resp_i,
    input  logic credit_avail_i,
    output logic issue_req_o,
    output logic capture_load_o,
    output logic retire_o,
    output logic slot_free_o
);

    typedef enum logic [1:0] {
        st_idle,
        st_wait_resp,
        st_wait_credit
    } state_t;

    state_t state;
    state_t state_nxt;
    logic   needs_mem;

    // misaligned accesses skip memory and retire with a trap
    assign needs_mem = mem_op_i && !misaligned_i;

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            state <= st_idle;
        end else begin
            state <= state_nxt;
        end
    end

    always_comb begin
        state_nxt      = state;
        issue_req_o    = 1'b0;
        capture_load_o = 1'b0;
        retire_o       = 1'b0;

        unique case (state)
            st_idle: begin
                if (slot_valid_i) begin
                    if (needs_mem) begin
                        issue_req_o = 1'b1; // one request per slot
                        state_nxt   = st_wait_resp;
                    end else if (credit_avail_i) begin
                        retire_o = 1'b1;
                    end else begin
                        state_nxt = st_wait_credit;
                    end
                end
            end
            st_wait_resp: begin
                if (dmem_resp_i) begin
                    capture_load_o = 1'b1;
                    state_nxt      = st_wait_credit;
                end
            end
            st_wait_credit: begin
                // also the normal landing spot after a response
                if (credit_avail_i) begin
                    retire_o  = 1'b1;
                    state_nxt = st_idle;
                end
            end
            default: state_nxt = st_idle;
        endcase
    end

    assign slot_free_o = retire_o; // slot empties as it retires

endmodule : dmem_ctrl

// File: hdl/credit_counter.sv
// up/down counter of write-back credits
`timescale 1ns/1ps

module credit_counter import rv32i_mem_pkg::*; (
    input  logic                clk,
    input  logic                rst,
    input  logic                spend_i,
    input  logic                return_i,
    output logic                credit_avail_o,
    output logic [CREDIT_W-1:0] count_o
);

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            count_o <= CREDIT_W'(WB_CREDITS); // consumer grant after reset
        end else if (spend_i && !return_i) begin
            count_o <= count_o - CREDIT_W'(1);
        end else if (return_i && !spend_i) begin
            count_o <= count_o + CREDIT_W'(1);
        end
        // spend and return together leave the count alone
    end

    assign credit_avail_o = (count_o != '0);

endmodule : credit_counter

// File: hdl/load_align.sv
// memory response capture with byte/half lane select and sign or zero extension
`timescale 1ns/1ps

module load_align import rv32i_mem_pkg::*; (
    input  logic         clk,
    input  logic         rst,
    input  logic         capture_i,
    input  rv_word_t     rdata_i,
    input  logic [1:0]   offset_i,
    input  load_funct3_t load_f3_i,
    output rv_word_t     load_data_o
);

    rv_word_t rdata_q;
    rv_word_t lane;   // addressed byte moved down to bit 0

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            rdata_q <= '0;
        end else if (capture_i) begin
            rdata_q <= rdata_i; // taken at the response edge
        end
    end

    assign lane = rdata_q >> {offset_i, 3'b000};

    always_comb begin
        unique case (load_f3_i)
            lb:      load_data_o = {{24{lane[7]}}, lane[7:0]};
            lh:      load_data_o = {{16{lane[15]}}, lane[15:0]};
            lbu:     load_data_o = {24'h00_0000, lane[7:0]};
            lhu:     load_data_o = {16'h0000, lane[15:0]};
            default: load_data_o = rdata_q; // lw, always offset 0
        endcase
    end

endmodule : load_align

// File: hdl/mem_wb_reg.sv
// MEM/WB register with write-back source select and retired instruction outputs
`timescale 1ns/1ps

module mem_wb_reg import rv32i_mem_pkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  logic     retire_i,
    input  wb_sel_t  wb_sel_i,
    input  rv_word_t alu_i,
    input  rv_word_t u_imm_i,
    input  rv_word_t pc_i,
    input  logic     br_en_i,
    input  rv_word_t load_data_i,
    input  reg_idx_t rd_i,
    input  logic     reg_we_i,
    input  logic     misaligned_i,
    output logic     wb_valid_o,
    output rv_word_t wb_data_o,
    output reg_idx_t wb_rd_o,
    output logic     wb_we_o,
    output logic     wb_trap_o,
    output rv_word_t wb_pc_o
);

    rv_word_t wb_data_d;

    always_comb begin
        unique case (wb_sel_i)
            sel_u_imm:    wb_data_d = u_imm_i;
            sel_pc_plus4: wb_data_d = pc_i + 32'd4;
            sel_br_en:    wb_data_d = rv_word_t'(br_en_i);
            sel_load:     wb_data_d = load_data_i;
            default:      wb_data_d = alu_i;
        endcase
    end

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            wb_valid_o <= 1'b0;
            wb_we_o    <= 1'b0;
            wb_trap_o  <= 1'b0;
        end else begin
            wb_valid_o <= retire_i; // one cycle per retirement
            if (retire_i) begin
                wb_we_o   <= reg_we_i && !misaligned_i; // trapped op writes nothing
                wb_trap_o <= misaligned_i;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (retire_i) begin
            wb_data_o <= wb_data_d;
            wb_rd_o   <= rd_i;
            wb_pc_o   <= pc_i;
        end
    end

endmodule : mem_wb_reg

// File: hdl/exe_mem_top.sv
// top level of the execute-to-memory slice connecting register, FSM, credits and write-back
`timescale 1ns/1ps

module exe_mem_top import rv32i_mem_pkg::*; (
    input  logic          clk,
    input  logic          rst,
    // execute side
    input  logic          ex_valid_i,
    input  rv_word_t      ex_alu_i,
    input  rv_word_t      ex_pc_i,
    input  rv_word_t      ex_rs2_i,
    input  rv_word_t      ex_u_imm_i,
    input  logic          ex_br_en_i,
    input  logic          ex_read_i,
    input  logic          ex_write_i,
    input  load_funct3_t  ex_load_f3_i,
    input  store_funct3_t ex_store_f3_i,
    input  wb_sel_t       ex_wb_sel_i,
    input  reg_idx_t      ex_rd_i,
    input  logic          ex_reg_we_i,
    output logic          ex_credit_o,
    // data memory
    output logic          dmem_req_o,
    output rv_word_t      dmem_addr_o,
    output rv_word_t      dmem_wdata_o,
    output byte_mask_t    dmem_wmask_o,
    output logic          dmem_read_o,
    input  logic          dmem_resp_i,
    input  rv_word_t      dmem_rdata_i,
    // write-back side
    input  logic          wb_credit_i,
    output logic          wb_valid_o,
    output rv_word_t      wb_data_o,
    output reg_idx_t      wb_rd_o,
    output logic          wb_we_o,
    output logic          wb_trap_o,
    output rv_word_t      wb_pc_o
);

    logic                slot_valid;
    logic                slot_free;
    logic                issue_req;
    logic                capture_load;
    logic                retire;
    logic                credit_avail;
    logic [CREDIT_W-1:0] wb_credit_cnt; // observed by the testbench
    logic                misaligned;
    logic                mem_write;
    rv_word_t            alu;
    rv_word_t            pc;
    rv_word_t            u_imm;
    logic                br_en;
    load_funct3_t        load_f3;
    wb_sel_t             wb_sel;
    reg_idx_t            rd;
    logic                reg_we;
    logic [1:0]          offset;
    rv_word_t            load_data;

    assign ex_credit_o = slot_free;
    assign dmem_req_o  = issue_req;

    exe_mem_reg exe_mem_reg_i (
        .clk           (clk),
        .rst           (rst),
        .ex_valid_i    (ex_valid_i),
        .ex_alu_i      (ex_alu_i),
        .ex_pc_i       (ex_pc_i),
        .ex_rs2_i      (ex_rs2_i),
        .ex_u_imm_i    (ex_u_imm_i),
        .ex_br_en_i    (ex_br_en_i),
        .ex_read_i     (ex_read_i),
        .ex_write_i    (ex_write_i),
        .ex_load_f3_i  (ex_load_f3_i),
        .ex_store_f3_i (ex_store_f3_i),
        .ex_wb_sel_i   (ex_wb_sel_i),
        .ex_rd_i       (ex_rd_i),
        .ex_reg_we_i   (ex_reg_we_i),
        .slot_free_i   (slot_free),
        .slot_valid_o  (slot_valid),
        .alu_o         (alu),
        .pc_o          (pc),
        .u_imm_o       (u_imm),
        .br_en_o       (br_en),
        .read_o        (dmem_read_o),
        .write_o       (mem_write),
        .load_f3_o     (load_f3),
        .wb_sel_o      (wb_sel),
        .rd_o          (rd),
        .reg_we_o      (reg_we),
        .addr_o        (dmem_addr_o),
        .mask_o        (dmem_wmask_o),
        .wdata_o       (dmem_wdata_o),
        .offset_o      (offset),
        .misaligned_o  (misaligned)
    );

    dmem_ctrl dmem_ctrl_i (
        .clk            (clk),
        .rst            (rst),
        .slot_valid_i   (slot_valid),
        .mem_op_i       (dmem_read_o || mem_write),
        .misaligned_i   (misaligned),
        .dmem_resp_i    (dmem_resp_i),
        .credit_avail_i (credit_avail),
        .issue_req_o    (issue_req),
        .capture_load_o (capture_load),
        .retire_o       (retire),
        .slot_free_o    (slot_free)
    );

    credit_counter credit_counter_i (
        .clk            (clk),
        .rst            (rst),
        .spend_i        (retire),
        .return_i       (wb_credit_i),
        .credit_avail_o (credit_avail),
        .count_o        (wb_credit_cnt)
    );

    load_align load_align_i (
        .clk         (clk),
        .rst         (rst),
        .capture_i   (capture_load),
        .rdata_i     (dmem_rdata_i),
        .offset_i    (offset),
        .load_f3_i   (load_f3),
        .load_data_o (load_data)
    );

    mem_wb_reg mem_wb_reg_i (
        .clk          (clk),
        .rst          (rst),
        .retire_i     (retire),
        .wb_sel_i     (wb_sel),
        .alu_i        (alu),
        .u_imm_i      (u_imm),
        .pc_i         (pc),
        .br_en_i      (br_en),
        .load_data_i  (load_data),
        .rd_i         (rd),
        .reg_we_i     (reg_we),
        .misaligned_i (misaligned),
        .wb_valid_o   (wb_valid_o),
        .wb_data_o    (wb_data_o),
        .wb_rd_o      (wb_rd_o),
        .wb_we_o      (wb_we_o),
        .wb_trap_o    (wb_trap_o),
        .wb_pc_o      (wb_pc_o)
    );

endmodule : exe_mem_top

// File: verification/tb_exe_mem.sv
// directed testbench for the execute-to-memory slice with memory, credit models and watchdog
`timescale 1ns/1ps

module tb_exe_mem import rv32i_mem_pkg::*; ();

    localparam int CLK_PERIOD = 40;
    localparam int DRIVE_DLY  = 2;
    localparam int NUM_TESTS  = 6;

    // one expected retirement
    typedef struct packed {
        rv_word_t    data;
        reg_idx_t    rd;
        logic        we;
        logic        trap;
        rv_word_t    pc;
        logic [31:0] acc;
        logic [31:0] lat; // 0 skips the latency check
    } retire_t;

    logic          clk;
    logic          rst;
    logic          ex_valid_i;
    rv_word_t      ex_alu_i;
    rv_word_t      ex_pc_i;
    rv_word_t      ex_rs2_i;
    rv_word_t      ex_u_imm_i;
    logic          ex_br_en_i;
    logic          ex_read_i;
    logic          ex_write_i;
    load_funct3_t  ex_load_f3_i;
    store_funct3_t ex_store_f3_i;
    wb_sel_t       ex_wb_sel_i;
    reg_idx_t      ex_rd_i;
    logic          ex_reg_we_i;
    logic          ex_credit_o;
    logic          dmem_req_o;
    rv_word_t      dmem_addr_o;
    rv_word_t      dmem_wdata_o;
    byte_mask_t    dmem_wmask_o;
    logic          dmem_read_o;
    logic          dmem_resp_i;
    rv_word_t      dmem_rdata_i;
    logic          wb_credit_i;
    logic          wb_valid_o;
    rv_word_t      wb_data_o;
    reg_idx_t      wb_rd_o;
    logic          wb_we_o;
    logic          wb_trap_o;
    rv_word_t      wb_pc_o;

    integer     seed = 32'hfcc7_d5a0;
    rv_word_t   mem [256];
    int         cycle = 0;
    int         ex_credits = EXE_MEM_SLOTS; // execute side credit count
    int         ex_credit_pulses = 0;
    int         credit_owed = 0;            // wb credits waiting to go back
    logic       auto_return = 1'b1;
    int         sent = 0;
    int         retired = 0;
    rv_word_t   pc_next = 32'h4000_0040;
    retire_t    exp_q [$];
    int         req_count = 0;
    rv_word_t   req_addr;
    rv_word_t   req_wdata;
    byte_mask_t req_mask;
    logic       req_read;

    exe_mem_top dut_i (.*);

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    always @(posedge clk) cycle <= cycle + 1;

    initial begin : watchdog
        #(2000 * NUM_TESTS * CLK_PERIOD);
        $display("ERROR: the run timed out after %0d cycles", 2000 * NUM_TESTS);
        $display("TEST RESULT: FAIL");
        $fatal(1, "timeout");
    end

    task automatic report_mismatch(input string msg);
        $display("FAILED at %0t: %s", $time, msg);
        $display("TEST RESULT: FAIL");
        $fatal(1, "value mismatch");
    endtask

    task automatic abort_run(input string why);
        $display("ERROR at %0t: %s", $time, why);
        $display("TEST RESULT: FAIL");
        $fatal(1, "run aborted");
    endtask

    task automatic check_word(input rv_word_t act, input rv_word_t exp, input string what);
        if (act !== exp) report_mismatch($sformatf("%s is %h, expected %h", what, act, exp));
    endtask

    task automatic check_mask(input byte_mask_t act, input byte_mask_t exp, input string what);
        if (act !== exp) report_mismatch($sformatf("%s is %b, expected %b", what, act, exp));
    endtask

    task automatic check_idx(input reg_idx_t act, input reg_idx_t exp, input string what);
        if (act !== exp) report_mismatch($sformatf("%s is %0d, expected %0d", what, act, exp));
    endtask

    task automatic check_bit(input logic act, input logic exp, input string what);
        if (act !== exp) report_mismatch($sformatf("%s is %b, expected %b", what, act, exp));
    endtask

    // memory answering after 1 to 4 cycles
    initial begin : memory_model
        int delay;
        dmem_resp_i  = 1'b0;
        dmem_rdata_i = '0;
        forever begin
            @(negedge clk);
            if (dmem_req_o) begin
                req_count++;
                req_addr  = dmem_addr_o;
                req_wdata = dmem_wdata_o;
                req_mask  = dmem_wmask_o;
                req_read  = dmem_read_o;
                delay = 1 + ({$random(seed)} % 4);
                repeat (delay) @(posedge clk);
                #(DRIVE_DLY);
                if (req_read) begin
                    dmem_rdata_i = mem[req_addr[9:2]];
                end else begin
                    // only masked bytes change
                    for (int b = 0; b < 4; b++) begin
                        if (req_mask[b]) mem[req_addr[9:2]][8*b +: 8] = req_wdata[8*b +: 8];
                    end
                end
                dmem_resp_i = 1'b1;
                @(posedge clk);
                #(DRIVE_DLY);
                dmem_resp_i = 1'b0;
            end
        end
    end

    // write-back consumer hands back one credit per cycle
    initial begin : wb_credit_model
        wb_credit_i = 1'b0;
        forever begin
            @(posedge clk);
            #(DRIVE_DLY);
            if (credit_owed > 0) begin
                wb_credit_i = 1'b1;
                credit_owed--;
            end else begin
                wb_credit_i = 1'b0;
            end
        end
    end

    always @(negedge clk) begin
        if (!rst && ex_credit_o) begin
            ex_credits++;
            ex_credit_pulses++;
        end
    end

    always @(negedge clk) begin : wb_monitor
        retire_t e;
        if (!rst && wb_valid_o) begin
            if (exp_q.size() == 0) begin
                abort_run("write-back valid seen with no instruction in flight");
            end else begin
                e = exp_q.pop_front(); // strictly in order
                check_word(wb_pc_o, e.pc, "wb_pc_o");
                check_idx(wb_rd_o, e.rd, "wb_rd_o");
                check_bit(wb_we_o, e.we, "wb_we_o");
                check_bit(wb_trap_o, e.trap, "wb_trap_o");
                if (!e.trap) check_word(wb_data_o, e.data, "wb_data_o");
                if (e.lat != 0) check_word(cycle - e.acc, e.lat, "cycles from accept to wb_valid_o");
                retired++;
                if (auto_return) credit_owed++;
            end
        end
    end

    function automatic rv_word_t expect_wb(input wb_sel_t sel, input rv_word_t alu,
                                           input rv_word_t pc, input rv_word_t u_imm,
                                           input logic br_en);
        case (sel)
            sel_u_imm:    return u_imm;
            sel_pc_plus4: return pc + 32'd4;
            sel_br_en:    return {31'd0, br_en};
            default:      return alu;
        endcase
    endfunction

    function automatic rv_word_t expect_load(input rv_word_t word, input logic [1:0] off,
                                             input load_funct3_t f3);
        logic [7:0]  b;
        logic [15:0] h;
        int          o;
        o = off;
        b = word[8*o +: 8];
        h = (o < 3) ? word[8*o +: 16] : 16'h0;
        case (f3)
            lb:      return rv_word_t'($signed(b));
            lbu:     return {24'h0, b};
            lh:      return rv_word_t'($signed(h));
            lhu:     return {16'h0, h};
            default: return word;
        endcase
    endfunction

    task automatic send_instr(input rv_word_t alu, input rv_word_t rs2, input rv_word_t u_imm,
                              input logic br_en, input logic rd_op, input logic wr_op,
                              input load_funct3_t lf3, input store_funct3_t sf3,
                              input wb_sel_t sel, input reg_idx_t rd, input logic we,
                              input rv_word_t exp_data, input logic exp_trap, input int lat);
        retire_t e;
        while (ex_credits == 0) @(negedge clk);
        @(posedge clk);
        #(DRIVE_DLY);
        ex_valid_i    = 1'b1;
        ex_alu_i      = alu;
        ex_pc_i       = pc_next;
        ex_rs2_i      = rs2;
        ex_u_imm_i    = u_imm;
        ex_br_en_i    = br_en;
        ex_read_i     = rd_op;
        ex_write_i    = wr_op;
        ex_load_f3_i  = lf3;
        ex_store_f3_i = sf3;
        ex_wb_sel_i   = sel;
        ex_rd_i       = rd;
        ex_reg_we_i   = we;
        ex_credits--;
        @(posedge clk); // accepting edge
        #(DRIVE_DLY);
        ex_valid_i = 1'b0;
        e.data = exp_data;
        e.rd   = rd;
        e.we   = we && !exp_trap;
        e.trap = exp_trap;
        e.pc   = pc_next;
        e.acc  = cycle;
        e.lat  = lat;
        exp_q.push_back(e);
        pc_next = pc_next + 32'd4;
        sent++;
    endtask

    task automatic send_alu(input wb_sel_t sel, input rv_word_t alu, input rv_word_t u_imm,
                            input logic br_en, input reg_idx_t rd, input logic we, input int lat);
        send_instr(alu, 32'h0, u_imm, br_en, 1'b0, 1'b0, lb, sb, sel, rd, we,
                   expect_wb(sel, alu, pc_next, u_imm, br_en), 1'b0, lat);
    endtask

    task automatic wait_drain();
        while (retired != sent || credit_owed != 0) @(negedge clk);
        @(posedge clk);
    endtask

    task automatic store_one(input store_funct3_t f3, input logic [1:0] off, input rv_word_t rs2);
        rv_word_t   addr;
        rv_word_t   lanes;
        rv_word_t   exp_word;
        byte_mask_t m;
        int         idx;
        int         reqs;
        addr = 32'h1000_0300 + rv_word_t'(off);
        idx  = addr[9:2];
        reqs = req_count;
        case (f3)
            sb:      m = 4'b0001 << off;
            sh:      m = 4'b0011 << off;
            default: m = 4'b1111;
        endcase
        lanes    = rs2 << (8 * off);
        exp_word = mem[idx];
        for (int b = 0; b < 4; b++) begin
            if (m[b]) exp_word[8*b +: 8] = lanes[8*b +: 8];
        end
        send_instr(addr, rs2, 32'h0, 1'b0, 1'b0, 1'b1, lb, f3, sel_alu, 5'd0, 1'b0,
                   addr, 1'b0, 0);
        wait_drain();
        check_word(req_count, reqs + 1, "memory requests per store");
        check_bit(req_read, 1'b0, "dmem_read_o on a store");
        check_word(req_addr, {addr[31:2], 2'b00}, "dmem_addr_o");
        check_mask(req_mask, m, "dmem_wmask_o");
        check_word(req_wdata, lanes, "dmem_wdata_o");
        check_word(mem[idx], exp_word, "memory word after store");
    endtask

    task automatic load_one(input load_funct3_t f3, input logic [1:0] off, input rv_word_t word);
        rv_word_t addr;
        int       reqs;
        addr = 32'h2000_0140 + rv_word_t'(off);
        reqs = req_count;
        mem[addr[9:2]] = word;
        send_instr(addr, 32'h0, 32'h0, 1'b0, 1'b1, 1'b0, f3, sb, sel_load, 5'd9, 1'b1,
                   expect_load(word, off, f3), 1'b0, 0);
        wait_drain();
        check_word(req_count, reqs + 1, "memory requests per load");
        check_bit(req_read, 1'b1, "dmem_read_o on a load");
        check_word(req_addr, {addr[31:2], 2'b00}, "dmem_addr_o");
    endtask

    task automatic reset_and_first_retire();
        @(negedge clk);
        check_bit(wb_valid_o, 1'b0, "wb_valid_o after reset");
        check_bit(dmem_req_o, 1'b0, "dmem_req_o after reset");
        check_bit(ex_credit_o, 1'b0, "ex_credit_o after reset");
        check_bit(wb_trap_o, 1'b0, "wb_trap_o after reset");
        check_word(dut_i.wb_credit_cnt, WB_CREDITS, "credit count after reset");
        send_alu(sel_alu, 32'h0000_1234, 32'h0, 1'b0, 5'd3, 1'b1, 2);
        wait_drain();
    endtask

    task automatic wb_select_cases();
        int reqs;
        reqs = req_count;
        send_alu(sel_alu, 32'hdead_beef, 32'h0, 1'b0, 5'd5, 1'b1, 2);
        send_alu(sel_u_imm, 32'h1111_1111, 32'habcd_e000, 1'b0, 5'd6, 1'b1, 2);
        send_alu(sel_pc_plus4, 32'h2222_2222, 32'h0, 1'b0, 5'd1, 1'b1, 2);
        send_alu(sel_br_en, 32'h3333_3333, 32'h0, 1'b1, 5'd7, 1'b1, 2);
        send_alu(sel_br_en, 32'h4444_4444, 32'h0, 1'b0, 5'd31, 1'b0, 2);
        wait_drain();
        check_word(req_count, reqs, "memory requests during ALU instructions");
    endtask

    task automatic store_lanes();
        for (int o = 0; o < 4; o++) store_one(sb, 2'(o), 32'ha1b2_c3d4 + o);
        for (int o = 0; o < 3; o++) store_one(sh, 2'(o), 32'h5e6f_7081 + o);
        store_one(sw, 2'd0, 32'hcafe_f00d);
    endtask

    task automatic load_extension();
        rv_word_t words [2];
        words[0] = 32'h80f1_92e3; // every byte and half negative
        words[1] = 32'h1274_3a05;
        for (int w = 0; w < 2; w++) begin
            for (int o = 0; o < 4; o++) begin
                load_one(lb, 2'(o), words[w]);
                load_one(lbu, 2'(o), words[w]);
                if (o < 3) begin
                    load_one(lh, 2'(o), words[w]);
                    load_one(lhu, 2'(o), words[w]);
                end
                if (o == 0) load_one(lw, 2'(o), words[w]);
            end
        end
    endtask

    task automatic misaligned_traps();
        int reqs;
        reqs = req_count;
        send_instr(32'h2000_0143, 32'h0, 32'h0, 1'b0, 1'b1, 1'b0, lh, sb, sel_load, 5'd11,
                   1'b1, 32'h0, 1'b1, 2);
        for (int o = 1; o < 4; o++) begin
            send_instr(32'h2000_0140 + o, 32'h0, 32'h0, 1'b0, 1'b1, 1'b0, lw, sb, sel_load,
                       5'd12, 1'b1, 32'h0, 1'b1, 2);
        end
        wait_drain();
        check_word(req_count, reqs, "memory requests for misaligned accesses");
    endtask

    task automatic credit_backpressure();
        int ret0;
        int pulses0;
        auto_return = 1'b0;
        ret0    = retired;
        pulses0 = ex_credit_pulses;
        send_alu(sel_alu, 32'h0000_0a01, 32'h0, 1'b0, 5'd13, 1'b1, 0);
        send_alu(sel_alu, 32'h0000_0a02, 32'h0, 1'b0, 5'd14, 1'b1, 0);
        send_alu(sel_u_imm, 32'h0, 32'h0000_3000, 1'b0, 5'd15, 1'b1, 0);
        repeat (20) @(negedge clk); // third one sits in the slot
        check_word(retired - ret0, WB_CREDITS, "retirements with credits withheld");
        check_word(ex_credit_pulses - pulses0, WB_CREDITS, "ex_credit_o pulses while stalled");
        check_bit(ex_credit_o, 1'b0, "ex_credit_o while stalled");
        check_word(ex_credits, 0, "execute credits while stalled");
        auto_return = 1'b1;
        credit_owed = credit_owed + WB_CREDITS;
        send_alu(sel_pc_plus4, 32'h0000_0a04, 32'h0, 1'b0, 5'd16, 1'b1, 0);
        send_alu(sel_alu, 32'h0000_0a05, 32'h0, 1'b0, 5'd17, 1'b1, 0);
        wait_drain();
        @(negedge clk);
        check_word(dut_i.wb_credit_cnt, WB_CREDITS, "credit count after all credits returned");
        check_word(ex_credit_pulses - pulses0, retired - ret0, "ex_credit_o pulses vs retirements");
    endtask

    initial begin
        rst           = 1'b1;
        ex_valid_i    = 1'b0;
        ex_alu_i      = '0;
        ex_pc_i       = '0;
        ex_rs2_i      = '0;
        ex_u_imm_i    = '0;
        ex_br_en_i    = 1'b0;
        ex_read_i     = 1'b0;
        ex_write_i    = 1'b0;
        ex_load_f3_i  = lb;
        ex_store_f3_i = sb;
        ex_wb_sel_i   = sel_alu;
        ex_rd_i       = '0;
        ex_reg_we_i   = 1'b0;
        for (int i = 0; i < 256; i++) mem[i] = (i + 1) * 32'h9e37_79b9;
        repeat (5) @(posedge clk);
        #(DRIVE_DLY);
        rst = 1'b0;

        reset_and_first_retire();
        wb_select_cases();
        store_lanes();
        load_extension();
        misaligned_traps();
        credit_backpressure();

        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule : tb_exe_mem

// File: flist.f
hdl/rv32i_mem_pkg.sv
hdl/exe_mem_reg.sv
hdl/dmem_ctrl.sv
hdl/credit_counter.sv
hdl/load_align.sv
hdl/mem_wb_reg.sv
hdl/exe_mem_top.sv
verification/tb_exe_mem.sv

// File: Bender.yml
package:
  name: rv32i_exe_mem

sources:
  - hdl/rv32i_mem_pkg.sv
  - hdl/exe_mem_reg.sv
  - hdl/dmem_ctrl.sv
  - hdl/credit_counter.sv
  - hdl/load_align.sv
  - hdl/mem_wb_reg.sv
  - hdl/exe_mem_top.sv
  - target: simulation
    files:
      - verification/tb_exe_mem.sv
